// File: src/rv_exec_consts.svh
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// widths fixed by the RV32 encoding
`define LEN_WORD  32
`define LEN_FUNC3 3
`define LEN_FUNC7 7

// base integer func3 codes
`define FUNC3_ADD  3'd0 // also SUB with func7[5]
`define FUNC3_SL   3'd1
`define FUNC3_SLT  3'd2
`define FUNC3_SLTU 3'd3
`define FUNC3_XOR  3'd4
`define FUNC3_SR   3'd5 // SRL, or SRA with func7[5]
`define FUNC3_OR   3'd6
`define FUNC3_AND  3'd7

// the only M-extension codes with real hardware behind them
`define FUNC3_DIVU 3'd5
`define FUNC3_REMU 3'd7

`define FUNC7_MEXT 7'b0000001

// one quotient bit per iteration
`define DIV_STEPS 32

`endif

// File: src/rv_exec_pkg.sv
`include "rv_exec_consts.svh"

package rv_exec_pkg;

    // operand and result word
    typedef logic [`LEN_WORD-1:0] word_t;

    typedef logic [`LEN_FUNC3-1:0] func3_t;
    typedef logic [`LEN_FUNC7-1:0] func7_t;

    // only the low bits of rs2 count for a shift
    typedef logic [$clog2(`LEN_WORD)-1:0] shamt_t;

    // wide enough to hold DIV_STEPS itself
    typedef logic [$clog2(`DIV_STEPS):0] step_t;

    // divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

// File: src/alu.sv
`timescale 1ns/1ps

`include "rv_exec_consts.svh"

`default_nettype none

module alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                order,
    output logic                accepted,
    output logic                done,
    input  rv_exec_pkg::func3_t func3,
    input  rv_exec_pkg::func7_t func7,
    input  rv_exec_pkg::word_t  rs1,
    input  rv_exec_pkg::word_t  rs2,
    output rv_exec_pkg::word_t  rd
);
    import rv_exec_pkg::*;

    logic   mode_flag;
    shamt_t shamt;
    word_t  calc_rd;
    word_t  rd_buf;

    // single cycle unit, every order completes where it is raised
    assign accepted = order;
    assign done     = order;

    assign mode_flag = func7[5]; // picks SUB and SRA
    assign shamt     = rs2[$bits(shamt_t)-1:0];

    always_comb begin
        case (func3)
            `FUNC3_ADD:  calc_rd = mode_flag ? (rs1 - rs2) : (rs1 + rs2);
            `FUNC3_SL:   calc_rd = rs1 << shamt;
            `FUNC3_SLT:  calc_rd = word_t'($signed(rs1) < $signed(rs2));
            `FUNC3_SLTU: calc_rd = word_t'(rs1 < rs2);
            `FUNC3_XOR:  calc_rd = rs1 ^ rs2;
            `FUNC3_SR:   calc_rd = mode_flag ? word_t'($signed(rs1) >>> shamt) : (rs1 >> shamt);
            `FUNC3_OR:   calc_rd = rs1 | rs2;
            `FUNC3_AND:  calc_rd = rs1 & rs2;
            default:     calc_rd = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_buf <= '0;
        end else if (done) begin
            rd_buf <= calc_rd;
        end
    end

    assign rd = done ? calc_rd : rd_buf; // new value shows in the done cycle

    // a result computed in the done cycle is held, so its inputs must be real values
    a_order_known: assert property (@(posedge clk) disable iff (rst)
        order |-> !$isunknown({func3, func7, rs1, rs2}));

endmodule

`default_nettype wire

// File: src/divu_remu.sv
`timescale 1ns/1ps

`include "rv_exec_consts.svh"

`default_nettype none

module divu_remu (
    input  logic               clk,
    input  logic               rst,
    input  logic               order,
    output logic               accepted,
    output logic               done,
    input  rv_exec_pkg::word_t dividend,
    input  rv_exec_pkg::word_t divisor,
    input  logic               want_rem,
    output rv_exec_pkg::word_t rd
);
    import rv_exec_pkg::*;

    div_state_t         state;
    step_t              step;
    word_t              quo;     // dividend bits shift out as quotient bits shift in
    word_t              rem;
    word_t              div_buf;
    logic               rem_sel;
    logic               iterate;
    logic [`LEN_WORD:0] partial;
    logic [`LEN_WORD:0] diff;

    assign accepted = order && (state == DIV_IDLE);
    assign done     = (state == DIV_DONE);

    // one extra RUN cycle at the end, so done lands 33 edges after acceptance
    assign iterate = (state == DIV_RUN) && (step != step_t'(`DIV_STEPS));

    // rem stays below the divisor, so the top bit of diff is the borrow
    assign partial = {rem, quo[`LEN_WORD-1]};
    assign diff    = partial - {1'b0, div_buf};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DIV_IDLE;
            step  <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (accepted) begin
                        state <= DIV_RUN;
                        step  <= '0;
                    end
                end
                DIV_RUN: begin
                    if (iterate) begin
                        step <= step + step_t'(1);
                    end else begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: state <= DIV_IDLE; // done is a single cycle
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            quo     <= dividend;
            rem     <= '0;
            div_buf <= divisor;
            rem_sel <= want_rem;
        end else if (iterate) begin
            // restore by keeping the shifted partial when the subtract borrows
            rem <= diff[`LEN_WORD] ? partial[`LEN_WORD-1:0] : diff[`LEN_WORD-1:0];
            quo <= {quo[`LEN_WORD-2:0], ~diff[`LEN_WORD]};
        end
    end

    // a zero divisor never borrows, giving all ones and the dividend back
    assign rd = rem_sel ? rem : quo;

    // done only ever follows the last RUN cycle
    a_done_after_run: assert property (@(posedge clk) disable iff (rst)
        done |-> (state == DIV_DONE) && ($past(state) == DIV_RUN)
                 && ($past(step) == step_t'(`DIV_STEPS)));

    // an accepted order always starts a fresh count
    a_accept_from_idle: assert property (@(posedge clk) disable iff (rst)
        accepted |=> (state == DIV_RUN) && (step == '0));

endmodule

`default_nettype wire

// File: src/alu_ext.sv
`timescale 1ns/1ps

`include "rv_exec_consts.svh"

`default_nettype none

module alu_ext (
    input  logic                clk,
    input  logic                rst,
    input  logic                order,
    output logic                accepted,
    output logic                done,
    output logic                busy,
    input  rv_exec_pkg::func3_t func3,
    input  rv_exec_pkg::word_t  rs1,
    input  rv_exec_pkg::word_t  rs2,
    output rv_exec_pkg::word_t  rd
);
    import rv_exec_pkg::*;

    logic  order_able;
    logic  is_div;
    logic  div_order;
    logic  div_accepted;
    logic  div_done;
    word_t div_rd;
    logic  error_order;
    word_t rd_buf;

    assign order_able = order && !busy;
    assign is_div     = (func3 == `FUNC3_DIVU) || (func3 == `FUNC3_REMU);

    assign div_order = order_able && is_div;

    divu_remu m_divu_remu (
        .clk      (clk),
        .rst      (rst),
        .order    (div_order),
        .accepted (div_accepted),
        .done     (div_done),
        .dividend (rs1),
        .divisor  (rs2),
        .want_rem (func3 == `FUNC3_REMU),
        .rd       (div_rd)
    );

    // MUL, MULH, DIV, REM and friends finish at once with zero
    assign error_order = order_able && !is_div;

    assign accepted = div_accepted || error_order;
    assign done     = div_done || error_order;

    // set by a multi-cycle acceptance, cleared by its done
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= !done && (busy || accepted);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_buf <= '0;
        end else if (done) begin
            rd_buf <= rd;
        end
    end

    assign rd = div_done    ? div_rd :
                error_order ? '0     : rd_buf;

    a_done_when_active: assert property (@(posedge clk) disable iff (rst)
        done |-> busy || order);

endmodule

`default_nettype wire

// File: src/exec_unit.sv
`timescale 1ns/1ps

`include "rv_exec_consts.svh"

`default_nettype none

module exec_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                order,
    output logic                accepted,
    output logic                done,
    input  rv_exec_pkg::func3_t func3,
    input  rv_exec_pkg::func7_t func7,
    input  rv_exec_pkg::word_t  rs1,
    input  rv_exec_pkg::word_t  rs2,
    output rv_exec_pkg::word_t  rd
);
    import rv_exec_pkg::*;

    logic  is_ext;
    logic  alu_order, alu_accepted, alu_done;
    logic  ext_order, ext_accepted, ext_done, ext_busy;
    word_t alu_rd;
    word_t ext_rd;
    logic  last_ext; // which unit produced the held result

    assign is_ext    = (func7 == `FUNC7_MEXT);
    assign alu_order = order && !is_ext && !ext_busy; // the only back-pressure
    assign ext_order = order && is_ext;               // alu_ext gates itself on busy

    alu m_alu (
        .clk(clk), .rst(rst),
        .order(alu_order), .accepted(alu_accepted), .done(alu_done),
        .func3(func3), .func7(func7), .rs1(rs1), .rs2(rs2), .rd(alu_rd)
    );

    alu_ext m_alu_ext (
        .clk(clk), .rst(rst),
        .order(ext_order), .accepted(ext_accepted), .done(ext_done), .busy(ext_busy),
        .func3(func3), .rs1(rs1), .rs2(rs2), .rd(ext_rd)
    );

    assign accepted = alu_accepted || ext_accepted;
    assign done     = alu_done || ext_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_ext <= 1'b0;
        end else if (done) begin
            last_ext <= ext_done;
        end
    end

    // each unit already holds its own last result
    assign rd = (ext_done || (!alu_done && last_ext)) ? ext_rd : alu_rd;

    // a pending order can only be a divide, and it must show up as busy
    a_pending_is_busy: assert property (@(posedge clk) disable iff (rst)
        (accepted && !done) |=> ext_busy && !alu_done);

endmodule

`default_nettype wire

// File: testbench/tb_exec_unit.sv
`timescale 1ns/1ps

`include "rv_exec_consts.svh"

module tb_exec_unit;
    import rv_exec_pkg::*;

    localparam func7_t ALT7 = 7'b0100000; // SUB and SRA
    localparam int BASE_OPS = 40 * 10 + 14 + 1 + 6 * 2 + 2;
    localparam int DIV_OPS  = 24 + 3 + 1 + 1;
    // a base order takes 2 cycles, a divide about 36
    localparam int TIMEOUT_CYCLES = (BASE_OPS * 2 + DIV_OPS * 36) * 3 / 2;

    logic   clk = 1'b0;
    logic   rst;
    logic   order;
    logic   accepted;
    logic   done;
    func3_t func3;
    func7_t func7;
    word_t  rs1;
    word_t  rs2;
    word_t  rd;

    integer      seed;
    int          word_errors = 0;
    int          bit_errors = 0;
    int          cycle_errors = 0;
    int unsigned cycles = 0;

    exec_unit i_dut (
        .clk      (clk),
        .rst      (rst),
        .order    (order),
        .accepted (accepted),
        .done     (done),
        .func3    (func3),
        .func7    (func7),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic word_t model_base(input func3_t f3, input func7_t f7,
                                         input word_t a, input word_t b);
        shamt_t sh;
        word_t  fill;
        sh   = b[4:0];
        fill = a[31] ? ~({`LEN_WORD{1'b1}} >> sh) : '0; // sign bits that SRA shifts in
        case (f3)
            `FUNC3_ADD:  return f7[5] ? a + ~b + 32'd1 : a + b;
            `FUNC3_SL:   return a << sh;
            `FUNC3_SLT:  return word_t'((a[31] != b[31]) ? a[31] : (a < b));
            `FUNC3_SLTU: return word_t'(a < b);
            `FUNC3_XOR:  return a ^ b;
            `FUNC3_SR:   return f7[5] ? (a >> sh) | fill : a >> sh;
            `FUNC3_OR:   return a | b;
            default:     return a & b;
        endcase
    endfunction

    // division by zero gives all ones, or the dividend as remainder
    function automatic word_t model_div(input func3_t f3, input word_t a, input word_t b);
        if (b == '0) begin
            return (f3 == `FUNC3_REMU) ? a : '1;
        end
        return (f3 == `FUNC3_REMU) ? a % b : a / b;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            word_errors++;
            $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            bit_errors++;
            $display("** Error at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            cycle_errors++;
            $display("** Error at %0t: %s, got %0d cycles expected %0d", $time, what, got, exp);
        end
    endtask

    // raises order until accepted, then lowers it on the next edge
    task automatic send_order(input func3_t f3, input func7_t f7, input word_t a, input word_t b,
                              output int waits, output logic done_now, output word_t rd_now);
        @(posedge clk);
        order <= 1'b1;
        func3 <= f3;
        func7 <= f7;
        rs1   <= a;
        rs2   <= b;
        waits = 0;
        @(negedge clk);
        while (!accepted) begin
            @(posedge clk);
            waits = waits + 1;
            @(negedge clk);
        end
        done_now = done;
        rd_now   = rd;
        @(posedge clk);
        order <= 1'b0;
    endtask

    task automatic wait_done(output int edges, output word_t result);
        logic seen;
        seen  = 1'b0;
        edges = 0;
        while (!seen) begin
            @(posedge clk);
            edges = edges + 1;
            @(negedge clk);
            seen = done;
        end
        result = rd;
    endtask

    task automatic run_base(input func3_t f3, input func7_t f7, input word_t a, input word_t b);
        int    waits;
        logic  done_now;
        word_t result;
        send_order(f3, f7, a, b, waits, done_now, result);
        check_cycles(waits, 0, "base order acceptance wait");
        check_bit(done_now, 1'b1, "base order done in its order cycle");
        check_word(result, model_base(f3, f7, a, b),
                   $sformatf("func3 %0d func7 %b with %h, %h", f3, f7, a, b));
    endtask

    task automatic run_div(input func3_t f3, input word_t a, input word_t b);
        int    waits;
        int    edges;
        logic  done_now;
        word_t result;
        send_order(f3, `FUNC7_MEXT, a, b, waits, done_now, result);
        check_cycles(waits, 0, "divide acceptance wait");
        check_bit(done_now, 1'b0, "divide done in its order cycle");
        wait_done(edges, result);
        check_cycles(edges, 33, "divide latency");
        check_word(result, model_div(f3, a, b), $sformatf("func3 %0d with %h, %h", f3, a, b));
    endtask

    task automatic check_hold(input word_t exp, input int idle);
        repeat (idle) begin
            @(negedge clk);
            check_bit(done, 1'b0, "done while idle");
            check_word(rd, exp, "held rd");
        end
    endtask

    task automatic test_base();
        word_t a;
        word_t b;
        for (int i = 0; i < 40; i++) begin
            a = $random(seed);
            b = $random(seed);
            for (int op = 0; op < 8; op++) begin
                run_base(func3_t'(op), 7'b0, a, b);
                if (func3_t'(op) == `FUNC3_ADD || func3_t'(op) == `FUNC3_SR) begin
                    run_base(func3_t'(op), ALT7, a, b);
                end
            end
        end
    endtask

    task automatic test_edges();
        run_base(`FUNC3_SL, 7'b0, 32'h8000_0001, 32'd0);
        run_base(`FUNC3_SL, 7'b0, 32'h8000_0001, 32'd31);
        run_base(`FUNC3_SR, 7'b0, 32'h8000_0000, 32'd31);
        run_base(`FUNC3_SR, ALT7, 32'h8000_0000, 32'd31);
        run_base(`FUNC3_SR, ALT7, 32'hf000_00f0, 32'd4);
        run_base(`FUNC3_SR, ALT7, 32'h8765_4321, 32'd0);
        run_base(`FUNC3_SR, ALT7, 32'h8765_4321, 32'h0000_0123); // only rs2[4:0] counts
        run_base(`FUNC3_SLT, 7'b0, 32'hffff_ffff, 32'd1);
        run_base(`FUNC3_SLTU, 7'b0, 32'hffff_ffff, 32'd1);
        run_base(`FUNC3_SLT, 7'b0, 32'd1, 32'h8000_0000);
        run_base(`FUNC3_SLTU, 7'b0, 32'd1, 32'h8000_0000);
        run_base(`FUNC3_ADD, 7'b0, 32'h7fff_ffff, 32'd1);
        run_base(`FUNC3_ADD, 7'b0, 32'hffff_ffff, 32'd1);
        run_base(`FUNC3_ADD, ALT7, 32'd0, 32'd1);
    endtask

    task automatic test_divide();
        word_t a;
        word_t b;
        for (int i = 0; i < 12; i++) begin
            a = $random(seed);
            b = $random(seed);
            b = b >> (i * 2); // smaller divisors give longer quotients
            run_div(`FUNC3_DIVU, a, b);
            run_div(`FUNC3_REMU, a, b);
        end
    endtask

    task automatic test_divide_by_zero();
        word_t a;
        a = $random(seed);
        run_div(`FUNC3_DIVU, a, '0);
        run_div(`FUNC3_REMU, a, '0);
        run_div(`FUNC3_DIVU, '0, '0);
    endtask

    task automatic test_back_pressure();
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        int    n;
        int    waits;
        logic  done_now;
        word_t result;
        a = $random(seed);
        b = $random(seed) >> 12;
        c = $random(seed);
        d = $random(seed);
        send_order(`FUNC3_REMU, `FUNC7_MEXT, a, b, waits, done_now, result);
        @(posedge clk);
        order <= 1'b1;
        func3 <= `FUNC3_SLTU;
        func7 <= 7'b0;
        rs1   <= c;
        rs2   <= d;
        n = 1;
        @(negedge clk);
        while (!done) begin
            check_bit(accepted, 1'b0, "base order accepted during a divide");
            @(posedge clk);
            n = n + 1;
            @(negedge clk);
        end
        check_cycles(n, 33, "divide latency with a waiting base order");
        check_bit(accepted, 1'b0, "base order accepted in the divide done cycle");
        check_word(rd, model_div(`FUNC3_REMU, a, b), "remainder with a waiting base order");
        @(posedge clk);
        @(negedge clk);
        check_bit(accepted, 1'b1, "waiting base order accepted after the divide");
        check_bit(done, 1'b1, "waiting base order done after the divide");
        check_word(rd, model_base(`FUNC3_SLTU, 7'b0, c, d), "waiting base order result");
        @(posedge clk);
        order <= 1'b0;
        // MUL, MULH, MULHSU, MULHU, DIV and REM have no hardware behind them
        for (int f = 0; f < 8; f++) begin
            if (func3_t'(f) != `FUNC3_DIVU && func3_t'(f) != `FUNC3_REMU) begin
                run_base(`FUNC3_OR, 7'b0, c, d | 32'd1); // rd holds a nonzero word before each
                send_order(func3_t'(f), `FUNC7_MEXT, c, d, waits, done_now, result);
                check_cycles(waits, 0, "unsupported M code acceptance wait");
                check_bit(done_now, 1'b1, "unsupported M code done in its order cycle");
                check_word(result, '0, "unsupported M code result");
            end
        end
    endtask

    task automatic test_hold();
        word_t a;
        word_t b;
        word_t exp;
        a = $random(seed);
        b = $random(seed);
        exp = model_base(`FUNC3_XOR, 7'b0, a, b);
        run_base(`FUNC3_XOR, 7'b0, a, b);
        check_hold(exp, 6);
        exp = model_div(`FUNC3_DIVU, a, b >> 8);
        run_div(`FUNC3_DIVU, a, b >> 8);
        check_hold(exp, 6); // the result before came from the ALU
        exp = model_base(`FUNC3_OR, 7'b0, b, a);
        run_base(`FUNC3_OR, 7'b0, b, a);
        check_hold(exp, 6);
    endtask

    initial begin
        seed = 32'hed0bf974;
        rst   <= 1'b1;
        order <= 1'b0;
        func3 <= '0;
        func7 <= '0;
        rs1   <= '0;
        rs2   <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_word(rd, '0, "rd after reset");
        check_bit(accepted, 1'b0, "accepted after reset");
        check_bit(done, 1'b0, "done after reset");
        test_base();
        test_edges();
        test_divide();
        test_divide_by_zero();
        test_back_pressure();
        test_hold();
        $display("errors: %0d word, %0d bit, %0d cycle count",
                 word_errors, bit_errors, cycle_errors);
        if (word_errors + bit_errors + cycle_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+src
src/rv_exec_pkg.sv
src/alu.sv
src/divu_remu.sv
src/alu_ext.sv
src/exec_unit.sv
testbench/tb_exec_unit.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_exec_unit \
    -f build.f -o tb_exec_unit > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_exec_unit > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -q "Result: PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
